/* design/amo_pkg.sv */
// Atomic operation definitions
package amo_pkg;

    // Operation field of an AtomicLoad or AtomicStore opcode
    typedef enum logic [2:0] {
        OP_ADD  = 3'b000,
        OP_CLR  = 3'b001,
        OP_EOR  = 3'b010,
        OP_SET  = 3'b011,
        OP_SMAX = 3'b100,
        OP_SMIN = 3'b101,
        OP_UMAX = 3'b110,
        OP_UMIN = 3'b111
    } amo_op_e;

    // Field view of the opcode, most significant field first
    typedef struct packed {
        logic [1:0] kind;
        logic       big_endian;
        amo_op_e    op;
    } atop_fields_t;

    // One opcode, read either as a whole code or by its fields
    typedef union packed {
        logic [5:0]   raw;
        atop_fields_t fields;
    } atop_t;

    // Whole codes of the swap/compare group
    localparam logic [5:0] ATOP_SWAP    = 6'b110000;
    localparam logic [5:0] ATOP_COMPARE = 6'b110001;

    // Kind field values
    localparam logic [1:0] ATOP_KIND_STORE = 2'b01;
    localparam logic [1:0] ATOP_KIND_LOAD  = 2'b10;

    // Transfer size code for a 32-bit word
    localparam logic [2:0] SIZE_WORD = 3'd2;

    // Request class handed from decode to execute
    typedef enum logic [1:0] {
        INVALID = 2'd0,
        LOAD    = 2'd1,
        STORE   = 2'd2,
        SWAP    = 2'd3
    } amo_class_e;

endpackage

/* design/amo_decode.sv */
// Atomic request decode stage
`timescale 1ns/1ps

module amo_decode #(
    parameter int unsigned AddrWidth = 32,
    parameter int unsigned WordWidth = 32
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 req_valid_i,
    output logic                 req_ready_o,
    input  amo_pkg::atop_t       req_atop_i,
    input  logic [AddrWidth-1:0] req_addr_i,
    input  logic [2:0]           req_size_i,
    input  logic [WordWidth-1:0] req_operand_i,
    output logic                 dec_valid_o,
    input  logic                 dec_ready_i,
    output amo_pkg::amo_class_e  dec_class_o,
    output amo_pkg::amo_op_e     dec_op_o,
    output logic [AddrWidth-1:0] dec_addr_o,
    output logic [WordWidth-1:0] dec_operand_o
);
    import amo_pkg::*;

    logic                 valid_q;
    logic                 accept;
    amo_class_e           req_class;
    amo_class_e           class_q;
    amo_op_e              op_q;
    logic [AddrWidth-1:0] addr_q;
    logic [WordWidth-1:0] operand_q;

    // Stage can take a new item when empty or when it drains this cycle
    assign req_ready_o = ~valid_q | dec_ready_i;
    assign accept      = req_valid_i & req_ready_o;

    always_comb begin
        req_class = INVALID;
        // Swap and compare are matched on the whole code
        if (req_atop_i.raw == ATOP_SWAP) begin
            req_class = SWAP;
        end else if (req_atop_i.raw == ATOP_COMPARE) begin
            req_class = INVALID;
        end else if (!req_atop_i.fields.big_endian) begin
            // Little-endian load and store by kind field
            if (req_atop_i.fields.kind == ATOP_KIND_LOAD) begin
                req_class = LOAD;
            end else if (req_atop_i.fields.kind == ATOP_KIND_STORE) begin
                req_class = STORE;
            end
        end
        // Only full words are supported
        if (req_size_i != SIZE_WORD) begin
            req_class = INVALID;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (dec_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            class_q   <= req_class;
            op_q      <= req_atop_i.fields.op;
            addr_q    <= req_addr_i;
            operand_q <= req_operand_i;
        end
    end

    assign dec_valid_o   = valid_q;
    assign dec_class_o   = class_q;
    assign dec_op_o      = op_q;
    assign dec_addr_o    = addr_q;
    assign dec_operand_o = operand_q;

endmodule

/* design/amo_alu.sv */
// Atomic arithmetic and logic unit
`timescale 1ns/1ps

module amo_alu #(
    parameter int unsigned WordWidth = 32
) (
    input  amo_pkg::amo_op_e     op_i,
    input  logic                 swap_i,
    input  logic [WordWidth-1:0] mem_val_i,
    input  logic [WordWidth-1:0] operand_i,
    output logic [WordWidth-1:0] result_o
);
    import amo_pkg::*;

    logic                 signed_lt;
    logic                 unsigned_lt;
    logic [WordWidth-1:0] op_result;

    // Old memory value against operand
    assign signed_lt   = $signed(mem_val_i) < $signed(operand_i);
    assign unsigned_lt = mem_val_i < operand_i;

    always_comb begin
        unique case (op_i)
            OP_ADD: begin
                op_result = mem_val_i + operand_i;
            end
            OP_CLR: begin
                op_result = mem_val_i & ~operand_i;
            end
            OP_EOR: begin
                op_result = mem_val_i ^ operand_i;
            end
            OP_SET: begin
                op_result = mem_val_i | operand_i;
            end
            OP_SMAX: begin
                op_result = signed_lt ? operand_i : mem_val_i;
            end
            OP_SMIN: begin
                op_result = signed_lt ? mem_val_i : operand_i;
            end
            OP_UMAX: begin
                op_result = unsigned_lt ? operand_i : mem_val_i;
            end
            OP_UMIN: begin
                op_result = unsigned_lt ? mem_val_i : operand_i;
            end
            default: begin
                op_result = mem_val_i;
            end
        endcase
    end

    // Swap ignores the op field and writes the operand as is
    assign result_o = swap_i ? operand_i : op_result;

endmodule

/* design/amo_exec.sv */
// Atomic read-modify-write stage
`timescale 1ns/1ps

module amo_exec #(
    parameter int unsigned DataWidth = 64,
    parameter int unsigned WordWidth = 32,
    parameter int unsigned AddrWidth = 32
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   dec_valid_i,
    output logic                   dec_ready_o,
    input  amo_pkg::amo_class_e    dec_class_i,
    input  amo_pkg::amo_op_e       dec_op_i,
    input  logic [AddrWidth-1:0]   dec_addr_i,
    input  logic [WordWidth-1:0]   dec_operand_i,
    output logic                   mem_req_valid_o,
    input  logic                   mem_req_ready_i,
    output logic                   mem_we_o,
    output logic [AddrWidth-1:0]   mem_addr_o,
    output logic [DataWidth-1:0]   mem_wdata_o,
    output logic [DataWidth/8-1:0] mem_wstrb_o,
    input  logic                   mem_rvalid_i,
    input  logic [DataWidth-1:0]   mem_rdata_i,
    output logic                   resp_valid_o,
    input  logic                   resp_ready_i,
    output logic [WordWidth-1:0]   resp_data_o,
    output logic                   resp_err_o
);
    import amo_pkg::*;

    localparam int unsigned Ratio     = DataWidth / WordWidth;
    localparam int unsigned WordBytes = WordWidth / 8;
    localparam int unsigned DataOffW  = $clog2(DataWidth / 8);
    localparam int unsigned WordOffW  = $clog2(WordBytes);
    localparam int unsigned LaneW     = (Ratio > 1) ? $clog2(Ratio) : 1;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ_REQ,
        ST_WAIT_DATA,
        ST_WRITE_REQ,
        ST_RESP
    } state_e;

    state_e state_d, state_q;

    logic                            take;
    logic                            write_done;
    amo_class_e                      class_q;
    amo_op_e                         op_q;
    logic [AddrWidth-1:0]            addr_q;
    logic [WordWidth-1:0]            operand_q;
    logic [Ratio-1:0][WordWidth-1:0] rdata_q;
    logic [WordWidth-1:0]            resp_data_q;
    logic                            resp_err_q;
    logic [LaneW-1:0]                lane;
    logic [WordWidth-1:0]            old_word;
    logic [WordWidth-1:0]            new_word;
    logic [Ratio-1:0][WordWidth-1:0] wdata_lanes;
    logic [Ratio-1:0][WordBytes-1:0] wstrb_lanes;

    assign take       = dec_valid_i & dec_ready_o;
    assign write_done = (state_q == ST_WRITE_REQ) & mem_req_ready_i;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            ST_IDLE: begin
                // Invalid items skip memory entirely
                if (dec_valid_i) begin
                    state_d = (dec_class_i == INVALID) ? ST_RESP : ST_READ_REQ;
                end
            end
            ST_READ_REQ: begin
                if (mem_req_ready_i) begin
                    state_d = ST_WAIT_DATA;
                end
            end
            ST_WAIT_DATA: begin
                if (mem_rvalid_i) begin
                    state_d = ST_WRITE_REQ;
                end
            end
            ST_WRITE_REQ: begin
                if (mem_req_ready_i) begin
                    state_d = ST_RESP;
                end
            end
            ST_RESP: begin
                if (resp_ready_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            class_q   <= dec_class_i;
            op_q      <= dec_op_i;
            addr_q    <= dec_addr_i;
            operand_q <= dec_operand_i;
        end
        if ((state_q == ST_WAIT_DATA) && mem_rvalid_i) begin
            rdata_q <= mem_rdata_i;
        end
        // Error response for an invalid item, old value otherwise
        if (take && (dec_class_i == INVALID)) begin
            resp_data_q <= '1;
            resp_err_q  <= 1'b1;
        end else if (write_done) begin
            resp_data_q <= (class_q == STORE) ? '0 : old_word;
            resp_err_q  <= 1'b0;
        end
    end

    // Lane index sits between the word and memory byte offsets
    if (Ratio > 1) begin : gen_lane
        assign lane = addr_q[DataOffW-1:WordOffW];
    end else begin : gen_single_lane
        assign lane = '0;
    end

    assign old_word = rdata_q[lane];

    amo_alu #(
        .WordWidth ( WordWidth )
    ) i_alu (
        .op_i      ( op_q             ),
        .swap_i    ( class_q == SWAP  ),
        .mem_val_i ( old_word         ),
        .operand_i ( operand_q        ),
        .result_o  ( new_word         )
    );

    // Other lanes keep the read value and are masked by the strobes anyway
    always_comb begin
        wdata_lanes       = rdata_q;
        wdata_lanes[lane] = new_word;
        wstrb_lanes       = '0;
        wstrb_lanes[lane] = '1;
    end

    assign dec_ready_o     = (state_q == ST_IDLE);
    assign mem_req_valid_o = (state_q == ST_READ_REQ) | (state_q == ST_WRITE_REQ);
    assign mem_we_o        = (state_q == ST_WRITE_REQ);
    assign mem_addr_o      = {addr_q[AddrWidth-1:DataOffW], {DataOffW{1'b0}}};
    assign mem_wdata_o     = wdata_lanes;
    assign mem_wstrb_o     = wstrb_lanes;
    assign resp_valid_o    = (state_q == ST_RESP);
    assign resp_data_o     = resp_data_q;
    assign resp_err_o      = resp_err_q;

endmodule

/* design/amo_unit.sv */
// Atomic memory operation unit
`timescale 1ns/1ps

module amo_unit #(
    parameter int unsigned DataWidth = 64,
    parameter int unsigned WordWidth = 32,
    parameter int unsigned AddrWidth = 32
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   req_valid_i,
    output logic                   req_ready_o,
    input  amo_pkg::atop_t         req_atop_i,
    input  logic [AddrWidth-1:0]   req_addr_i,
    input  logic [2:0]             req_size_i,
    input  logic [WordWidth-1:0]   req_operand_i,
    output logic                   mem_req_valid_o,
    input  logic                   mem_req_ready_i,
    output logic                   mem_we_o,
    output logic [AddrWidth-1:0]   mem_addr_o,
    output logic [DataWidth-1:0]   mem_wdata_o,
    output logic [DataWidth/8-1:0] mem_wstrb_o,
    input  logic                   mem_rvalid_i,
    input  logic [DataWidth-1:0]   mem_rdata_i,
    output logic                   resp_valid_o,
    input  logic                   resp_ready_i,
    output logic [WordWidth-1:0]   resp_data_o,
    output logic                   resp_err_o
);
    import amo_pkg::*;

    // Decode to execute
    logic                 dec_valid;
    logic                 dec_ready;
    amo_class_e           dec_class;
    amo_op_e              dec_op;
    logic [AddrWidth-1:0] dec_addr;
    logic [WordWidth-1:0] dec_operand;

    amo_decode #(
        .AddrWidth ( AddrWidth ),
        .WordWidth ( WordWidth )
    ) i_decode (
        .clk_i         ( clk_i         ),
        .rst_ni        ( rst_ni        ),
        .req_valid_i   ( req_valid_i   ),
        .req_ready_o   ( req_ready_o   ),
        .req_atop_i    ( req_atop_i    ),
        .req_addr_i    ( req_addr_i    ),
        .req_size_i    ( req_size_i    ),
        .req_operand_i ( req_operand_i ),
        .dec_valid_o   ( dec_valid     ),
        .dec_ready_i   ( dec_ready     ),
        .dec_class_o   ( dec_class     ),
        .dec_op_o      ( dec_op        ),
        .dec_addr_o    ( dec_addr      ),
        .dec_operand_o ( dec_operand   )
    );

    amo_exec #(
        .DataWidth ( DataWidth ),
        .WordWidth ( WordWidth ),
        .AddrWidth ( AddrWidth )
    ) i_exec (
        .clk_i           ( clk_i           ),
        .rst_ni          ( rst_ni          ),
        .dec_valid_i     ( dec_valid       ),
        .dec_ready_o     ( dec_ready       ),
        .dec_class_i     ( dec_class       ),
        .dec_op_i        ( dec_op          ),
        .dec_addr_i      ( dec_addr        ),
        .dec_operand_i   ( dec_operand     ),
        .mem_req_valid_o ( mem_req_valid_o ),
        .mem_req_ready_i ( mem_req_ready_i ),
        .mem_we_o        ( mem_we_o        ),
        .mem_addr_o      ( mem_addr_o      ),
        .mem_wdata_o     ( mem_wdata_o     ),
        .mem_wstrb_o     ( mem_wstrb_o     ),
        .mem_rvalid_i    ( mem_rvalid_i    ),
        .mem_rdata_i     ( mem_rdata_i     ),
        .resp_valid_o    ( resp_valid_o    ),
        .resp_ready_i    ( resp_ready_i    ),
        .resp_data_o     ( resp_data_o     ),
        .resp_err_o      ( resp_err_o      )
    );

endmodule

/* tb/tb_clock_gen.sv */
// Testbench clock source
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PeriodNs = 100.0
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PeriodNs / 2.0) clk_o = ~clk_o;
        end
    end

endmodule

/* tb/amo_unit_properties.sv */
// Atomic unit handshake properties
`timescale 1ns/1ps

module amo_unit_properties #(
    parameter int unsigned DataWidth = 64,
    parameter int unsigned WordWidth = 32,
    parameter int unsigned AddrWidth = 32
) (
    input logic                   clk_i,
    input logic                   rst_ni,
    input logic                   mem_req_valid_o,
    input logic                   mem_req_ready_i,
    input logic                   mem_we_o,
    input logic [AddrWidth-1:0]   mem_addr_o,
    input logic [DataWidth-1:0]   mem_wdata_o,
    input logic [DataWidth/8-1:0] mem_wstrb_o,
    input logic                   mem_rvalid_i,
    input logic                   resp_valid_o,
    input logic                   resp_ready_i,
    input logic [WordWidth-1:0]   resp_data_o,
    input logic                   resp_err_o
);

    // Failed assertion count
    int unsigned fail_count = 0;
    logic        read_open_q;

    // A read stays open from its acceptance until its data returns
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            read_open_q <= 1'b0;
        end else if (mem_req_valid_o && mem_req_ready_i && !mem_we_o) begin
            read_open_q <= 1'b1;
        end else if (mem_rvalid_i) begin
            read_open_q <= 1'b0;
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o &&
            $stable({mem_we_o, mem_addr_o, mem_wdata_o, mem_wstrb_o}))
    else begin
        $error("memory request changed before it was accepted");
        fail_count++;
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable({resp_data_o, resp_err_o}))
    else begin
        $error("response changed before it was accepted");
        fail_count++;
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_rvalid_i |-> read_open_q)
    else begin
        $error("read data returned with no read outstanding");
        fail_count++;
    end

endmodule

bind amo_unit amo_unit_properties #(
    .DataWidth ( DataWidth ),
    .WordWidth ( WordWidth ),
    .AddrWidth ( AddrWidth )
) i_props (.*);

/* tb/amo_unit_tb.sv */
// Atomic unit testbench
`timescale 1ns/1ps

module amo_unit_tb;

    localparam int unsigned NumReq        = 300;
    localparam int unsigned TimeoutCycles = NumReq * 40;
    localparam logic [5:0]  CodeSwap      = 6'b110000;
    localparam logic [5:0]  CodeCompare   = 6'b110001;

    logic        clk_i;
    logic        rst_ni;
    logic        req_valid_i;
    logic        req_ready_o;
    logic [5:0]  req_atop_i;
    logic [31:0] req_addr_i;
    logic [2:0]  req_size_i;
    logic [31:0] req_operand_i;
    logic        mem_req_valid_o;
    logic        mem_req_ready_i;
    logic        mem_we_o;
    logic [31:0] mem_addr_o;
    logic [63:0] mem_wdata_o;
    logic [7:0]  mem_wstrb_o;
    logic        mem_rvalid_i;
    logic [63:0] mem_rdata_i;
    logic        resp_valid_o;
    logic        resp_ready_i;
    logic [31:0] resp_data_o;
    logic        resp_err_o;

    // Memory model, shadow copy and expected results
    logic [31:0] seed = 32'h4af2;
    logic [63:0] mem [16];
    logic [63:0] shadow [16];
    logic [31:0] exp_data_q [$];
    logic        exp_err_q [$];
    logic [63:0] exp_word_q [$];
    logic [7:0]  exp_strb_q [$];
    logic        req_fire;
    int unsigned rd_wait;
    logic [3:0]  rd_idx;
    int unsigned issued;
    int unsigned received;
    int unsigned cycles = 0;

    tb_clock_gen #(.PeriodNs(100.0)) i_clock (.clk_o(clk_i));

    amo_unit UUT (.*);

    function automatic logic [31:0] lcg_step();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Upper bits only, the low LCG bits repeat quickly
    function automatic int unsigned pick_below(input int unsigned n);
        logic [31:0] r;
        r = lcg_step();
        return r[31:16] % n;
    endfunction

    function automatic logic [31:0] random_word();
        return {16'(pick_below(65536)), 16'(pick_below(65536))};
    endfunction

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            report_failure($sformatf("error: %s is %h, expected %h", name, got, expected));
        end
    endtask

    // AtomicLoad and AtomicStore arithmetic
    function automatic logic [31:0] atomic_result(input logic [2:0] op,
                                                  input logic [31:0] old_val,
                                                  input logic [31:0] arg);
        case (op)
            3'd0: return old_val + arg;
            3'd1: return old_val & ~arg;
            3'd2: return old_val ^ arg;
            3'd3: return old_val | arg;
            3'd4: return ($signed(old_val) > $signed(arg)) ? old_val : arg;
            3'd5: return ($signed(old_val) < $signed(arg)) ? old_val : arg;
            3'd6: return (old_val > arg) ? old_val : arg;
            default: return (old_val < arg) ? old_val : arg;
        endcase
    endfunction

    // Mostly loads and stores, some swaps and invalid codes
    task automatic make_request();
        logic [2:0] op;
        op = 3'(pick_below(8));
        case (pick_below(8))
            0, 1, 2: req_atop_i = {2'b10, 1'b0, op};
            3, 4:    req_atop_i = {2'b01, 1'b0, op};
            5:       req_atop_i = CodeSwap;
            6:       req_atop_i = (pick_below(2) != 0) ? CodeCompare : {2'b10, 1'b1, op};
            default: req_atop_i = (pick_below(2) != 0) ? 6'b0 : 6'(pick_below(64));
        endcase
        req_size_i    = (pick_below(16) == 0) ? 3'(pick_below(8)) : 3'd2;
        req_addr_i    = 32'(pick_below(32)) << 2;
        req_operand_i = random_word();
        req_valid_i   = 1'b1;
    endtask

    // Requests applied to the shadow memory in acceptance order
    task automatic model_request();
        logic        is_swap;
        logic        is_load;
        logic        is_store;
        int unsigned base;
        logic [3:0]  idx;
        logic [31:0] old_val;
        logic [31:0] new_val;
        idx      = req_addr_i[6:3];
        base     = req_addr_i[2] ? 32 : 0;
        old_val  = shadow[idx][base +: 32];
        is_swap  = (req_atop_i == CodeSwap);
        is_load  = (req_atop_i[5:3] == 3'b100);
        is_store = (req_atop_i[5:3] == 3'b010);
        if ((req_size_i != 3'd2) || !(is_swap || is_load || is_store)) begin
            exp_data_q.push_back('1);
            exp_err_q.push_back(1'b1);
        end else begin
            new_val = is_swap ? req_operand_i
                              : atomic_result(req_atop_i[2:0], old_val, req_operand_i);
            shadow[idx][base +: 32] = new_val;
            exp_word_q.push_back(shadow[idx]);
            // Only the four bytes of the addressed word are written
            exp_strb_q.push_back(req_addr_i[2] ? 8'hf0 : 8'h0f);
            exp_data_q.push_back(is_store ? 32'd0 : old_val);
            exp_err_q.push_back(1'b0);
        end
    endtask

    // Inputs for the next rising edge, and the transfers it will make
    task automatic service_cycle();
        logic [3:0] idx;
        int         b;
        if (req_fire) begin
            req_valid_i = 1'b0;
            req_fire    = 1'b0;
        end
        if (!req_valid_i && (issued < NumReq) && (pick_below(4) != 0)) begin
            make_request();
        end
        if (req_valid_i && req_ready_o) begin
            model_request();
            issued++;
            req_fire = 1'b1;
        end
        // Read data after a delay of one to four cycles
        mem_rvalid_i = 1'b0;
        mem_rdata_i  = {random_word(), random_word()};
        if (rd_wait != 0) begin
            rd_wait--;
            if (rd_wait == 0) begin
                mem_rvalid_i = 1'b1;
                mem_rdata_i  = mem[rd_idx];
            end
        end
        mem_req_ready_i = (pick_below(4) != 0);
        if (mem_req_valid_o && mem_req_ready_i) begin
            check_value("mem_addr_o[2:0]", mem_addr_o[2:0], 0);
            idx = mem_addr_o[6:3];
            if (!mem_we_o) begin
                rd_idx  = idx;
                rd_wait = 1 + pick_below(4);
            end else if (exp_word_q.size() == 0) begin
                report_failure("memory write with no valid request waiting for it");
            end else begin
                check_value("mem_wstrb_o", mem_wstrb_o, exp_strb_q.pop_front());
                for (b = 0; b < 8; b++) begin
                    if (mem_wstrb_o[b]) begin
                        mem[idx][8*b +: 8] = mem_wdata_o[8*b +: 8];
                    end
                end
                check_value("memory word after write", mem[idx], exp_word_q.pop_front());
            end
        end
        resp_ready_i = (pick_below(3) != 0);
        if (resp_valid_o && resp_ready_i) begin
            if (exp_data_q.size() == 0) begin
                report_failure("response arrived with no request outstanding");
            end else begin
                check_value("resp_data_o", resp_data_o, exp_data_q.pop_front());
                check_value("resp_err_o", resp_err_o, exp_err_q.pop_front());
                received++;
            end
        end
    endtask

    initial begin
        int i;
        rst_ni          = 1'b0;
        req_valid_i     = 1'b0;
        req_atop_i      = '0;
        req_addr_i      = '0;
        req_size_i      = 3'd2;
        req_operand_i   = '0;
        mem_req_ready_i = 1'b0;
        mem_rvalid_i    = 1'b0;
        mem_rdata_i     = '0;
        resp_ready_i    = 1'b0;
        req_fire        = 1'b0;
        rd_wait         = 0;
        rd_idx          = '0;
        issued          = 0;
        received        = 0;
        for (i = 0; i < 16; i++) begin
            mem[i]    = {random_word(), random_word()};
            shadow[i] = mem[i];
        end
        repeat (8) @(negedge clk_i);
        rst_ni = 1'b1;
        check_value("req_ready_o", req_ready_o, 1);
        check_value("mem_req_valid_o", mem_req_valid_o, 0);
        check_value("resp_valid_o", resp_valid_o, 0);
        while (received < NumReq) begin
            @(negedge clk_i);
            cycles++;
            if (cycles > TimeoutCycles) begin
                report_failure($sformatf("timeout: %0d of %0d responses after %0d cycles",
                                         received, NumReq, cycles));
            end else begin
                service_cycle();
            end
        end
        // Every write done and memory matches the shadow copy
        check_value("memory writes still expected", exp_word_q.size(), 0);
        for (i = 0; i < 16; i++) begin
            check_value($sformatf("memory word %0d", i), mem[i], shadow[i]);
        end
        if (UUT.i_props.fail_count != 0) begin
            report_failure("handshake assertions failed during the run");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

/* filelist.f */
design/amo_pkg.sv
design/amo_decode.sv
design/amo_alu.sv
design/amo_exec.sv
design/amo_unit.sv
tb/tb_clock_gen.sv
tb/amo_unit_properties.sv
tb/amo_unit_tb.sv

/* Bender.yml */
package:
  name: amo_unit

sources:
  - design/amo_pkg.sv
  - design/amo_decode.sv
  - design/amo_alu.sv
  - design/amo_exec.sv
  - design/amo_unit.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/amo_unit_properties.sv
      - tb/amo_unit_tb.sv
